//--- design/bridge_settings.svh
// ********************
// bit period is counted in clock cycles, not derived from a baud rate
// address width sets the RAM size, upper command address bits are dropped
// ********************
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// clock cycles per serial bit, keep it even for a clean half-bit point
`define BRIDGE_BIT_CYCLES 16

// RAM address width, 10 gives 1024 bytes
`define BRIDGE_ADDR_W 10

// opcode byte values on the command channel
`define BRIDGE_OP_WRITE 8'h57
`define BRIDGE_OP_READ  8'h52

`endif

//--- design/byte_ram.sv
// ********************
// single port, read is registered, contents undefined until written
// ********************
`timescale 1ns/1ps
`include "bridge_settings.svh"

module byte_ram (
    input  logic                      clk,
    input  logic                      ram_we,
    input  logic [`BRIDGE_ADDR_W-1:0] ram_addr,
    input  logic [7:0]                ram_wdata,
    output logic [7:0]                ram_rdata
);

    localparam int DEPTH = 2 ** `BRIDGE_ADDR_W;

    logic [7:0] mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (ram_we) mem[ram_addr] <= ram_wdata;
        ram_rdata <= mem[ram_addr];  // old data on a same-address write
    end

endmodule

//--- design/cmd_engine.sv
// ********************
// frame is opcode, addr hi, addr lo, length; length 0 means 256 bytes
// rx bytes during a read are dropped, the host must space its commands
// ********************
`timescale 1ns/1ps
`include "bridge_settings.svh"

module cmd_engine import cmd_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                rx_dat,
    input  logic                      rx_stb,
    input  logic [7:0]                ram_rdata,
    input  logic                      tx_busy,
    output logic [`BRIDGE_ADDR_W-1:0] ram_addr,
    output logic [7:0]                ram_wdata,
    output logic                      ram_we,
    output logic [7:0]                tx_dat,
    output logic                      tx_start,
    output logic                      busy
);

    localparam int ADDR_W = `BRIDGE_ADDR_W;

    cmd_stage_t        stage;
    cmd_op_t           op;
    logic [7:0]        addr_hi;
    logic [ADDR_W-1:0] addr;
    logic [8:0]        count;  // bytes left, up to 256

    assign ram_addr = addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage    <= stage_opcode;
            ram_we   <= 1'b0;
            tx_start <= 1'b0;
            busy     <= 1'b0;
        end else begin
            ram_we   <= 1'b0;
            tx_start <= 1'b0;
            if (ram_we) addr <= addr + 1'b1;  // step after each write lands
            case (stage)
                stage_opcode: begin
                    if (rx_stb && (rx_dat == op_write || rx_dat == op_read)) begin
                        op    <= cmd_op_t'(rx_dat);
                        busy  <= 1'b1;
                        stage <= stage_addr_hi;
                    end
                end
                stage_addr_hi: if (rx_stb) begin
                    addr_hi <= rx_dat;
                    stage   <= stage_addr_lo;
                end
                stage_addr_lo: if (rx_stb) begin
                    addr  <= ADDR_W'({addr_hi, rx_dat});  // upper bits ignored
                    stage <= stage_length;
                end
                stage_length: if (rx_stb) begin
                    count <= (rx_dat == 8'd0) ? 9'd256 : {1'b0, rx_dat};
                    stage <= (op == op_write) ? stage_write_data : stage_read_fetch;
                end
                stage_write_data: if (rx_stb) begin
                    ram_wdata <= rx_dat;
                    ram_we    <= 1'b1;
                    count     <= count - 1'b1;
                    if (count == 9'd1) begin
                        stage <= stage_opcode;
                        busy  <= 1'b0;
                    end
                end
                stage_read_fetch: stage <= stage_read_send;  // ram_rdata valid next
                default: if (!tx_busy) begin
                    tx_dat   <= ram_rdata;
                    tx_start <= 1'b1;
                    addr     <= addr + 1'b1;
                    count    <= count - 1'b1;
                    if (count == 9'd1) begin
                        stage <= stage_opcode;
                        busy  <= 1'b0;
                    end else begin
                        stage <= stage_read_fetch;
                    end
                end
            endcase
        end
    end

    // writes and reads never overlap
    assert property (@(posedge clk) disable iff (rst) !(ram_we && tx_start))
        else $error("cmd_engine: RAM write and tx start in the same cycle");

    assert property (@(posedge clk) disable iff (rst) (stage != stage_opcode) |-> busy)
        else $error("cmd_engine: busy low in the middle of a command");

endmodule

//--- design/cmd_pkg.sv
// ********************
// opcode values come from the settings header
// ********************
`include "bridge_settings.svh"

package cmd_pkg;

    typedef enum logic [7:0] {
        op_write = `BRIDGE_OP_WRITE,
        op_read  = `BRIDGE_OP_READ
    } cmd_op_t;

    typedef enum logic [2:0] {
        stage_opcode,       // idle, waiting for a known opcode
        stage_addr_hi,
        stage_addr_lo,
        stage_length,
        stage_write_data,   // one rx byte per RAM write
        stage_read_fetch,   // RAM read latency slot
        stage_read_send     // waits for the transmitter
    } cmd_stage_t;

endpackage

//--- design/serial_mem_bridge.sv
// ********************
// UART command bridge to an internal byte RAM
// ********************
`timescale 1ns/1ps
`include "bridge_settings.svh"

module serial_mem_bridge (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic tx,
    output logic busy,
    output logic frame_err
);

    logic [7:0]                rx_dat;
    logic                      rx_stb;
    logic [`BRIDGE_ADDR_W-1:0] ram_addr;
    logic [7:0]                ram_wdata;
    logic [7:0]                ram_rdata;
    logic                      ram_we;
    logic [7:0]                tx_dat;
    logic                      tx_start;
    logic                      tx_busy;

    uart_rx uart_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .rx_dat    (rx_dat),
        .rx_stb    (rx_stb),
        .frame_err (frame_err)  // straight to the pin
    );

    byte_ram byte_ram_inst (
        .clk       (clk),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    cmd_engine cmd_engine_inst (
        .clk       (clk),
        .rst       (rst),
        .rx_dat    (rx_dat),
        .rx_stb    (rx_stb),
        .ram_rdata (ram_rdata),
        .tx_busy   (tx_busy),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .tx_dat    (tx_dat),
        .tx_start  (tx_start),
        .busy      (busy)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .tx_dat   (tx_dat),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

//--- design/uart_pkg.sv
// ********************
// state encodings for the 8N1 receiver and transmitter
// ********************
package uart_pkg;

    typedef enum logic [1:0] {
        rx_idle,   // waiting for a falling edge
        rx_start,  // checking the start bit
        rx_data,   // eight data bits
        rx_stop    // stop bit check
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

//--- design/uart_rx.sv
// ********************
// 8N1 receiver, no parity, a low stop bit gives frame_err and no strobe
// ********************
`timescale 1ns/1ps
`include "bridge_settings.svh"

module uart_rx import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_dat,
    output logic       rx_stb,
    output logic       frame_err
);

    localparam int BIT_CYCLES = `BRIDGE_BIT_CYCLES;
    localparam int CNT_W = $clog2(BIT_CYCLES);

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0] bit_idx;
    logic [7:0] shreg;

    assign rx_dat = shreg;  // stable during the strobe cycle

    always_ff @(posedge clk) begin
        rx_meta <= rx;
        rx_sync <= rx_meta;
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= rx_idle;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_stb    <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_stb    <= 1'b0;
            frame_err <= 1'b0;
            cnt       <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rx_sync) state <= rx_start;
                end
                rx_start: if (cnt == CNT_W'(BIT_CYCLES / 2 - 1)) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync ? rx_idle : rx_data;  // glitch goes back to idle
                end
                rx_data: if (cnt == CNT_W'(BIT_CYCLES - 1)) begin
                    cnt     <= '0;
                    shreg   <= {rx_sync, shreg[7:1]};  // lsb first
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= rx_stop;
                end
                default: if (cnt == CNT_W'(BIT_CYCLES - 1)) begin
                    rx_stb    <= rx_sync;
                    frame_err <= !rx_sync;
                    state     <= rx_idle;
                end
            endcase
        end
    end

endmodule

//--- design/uart_tx.sv
// ********************
// 8N1 transmitter, tx_start is only legal while tx_busy is low
// ********************
`timescale 1ns/1ps
`include "bridge_settings.svh"

module uart_tx import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_dat,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);

    localparam int BIT_CYCLES = `BRIDGE_BIT_CYCLES;
    localparam int CNT_W = $clog2(BIT_CYCLES);

    tx_state_t  state;
    logic [CNT_W-1:0] cnt;
    logic [2:0] bit_idx;
    logic [7:0] shreg;

    assign tx_busy = (state != tx_idle);  // 10 bit periods per byte

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= tx_idle;
            tx      <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                tx_idle: begin
                    cnt <= '0;
                    if (tx_start) begin
                        shreg   <= tx_dat;
                        tx      <= 1'b0;  // start bit
                        bit_idx <= '0;
                        state   <= uart_pkg::tx_start;  // port shares the name
                    end
                end
                uart_pkg::tx_start: if (cnt == CNT_W'(BIT_CYCLES - 1)) begin
                    cnt   <= '0;
                    tx    <= shreg[0];
                    shreg <= {1'b1, shreg[7:1]};
                    state <= tx_data;
                end
                tx_data: if (cnt == CNT_W'(BIT_CYCLES - 1)) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    tx      <= shreg[0];  // all ones once the byte is out
                    shreg   <= {1'b1, shreg[7:1]};
                    if (bit_idx == 3'd7) state <= tx_stop;
                end
                default: if (cnt == CNT_W'(BIT_CYCLES - 1)) state <= tx_idle;
            endcase
        end
    end

    // the engine has to wait out the whole frame before the next byte
    assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
        else $error("uart_tx: tx_start while a byte is still on the line");

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f serial_mem_bridge.f --top-module tb_serial_mem_bridge \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

//--- serial_mem_bridge.f
+incdir+design
design/uart_pkg.sv
design/cmd_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/byte_ram.sv
design/cmd_engine.sv
design/serial_mem_bridge.sv
test/bridge_checker.sv
test/tb_serial_mem_bridge.sv

//--- test/bridge_checker.sv
// ********************
// decodes tx at mid-bit, expected bytes are queued by the testbench
// ********************
`timescale 1ns/1ps
`include "bridge_settings.svh"

module bridge_checker (
    input  logic clk,
    input  logic rst,
    input  logic tx,
    input  logic frame_err,
    input  logic ferr_expected,
    output int   errors,
    output int   ferr_seen
);

    localparam int BIT_CYCLES = `BRIDGE_BIT_CYCLES;

    logic [7:0] exp_q [$];
    logic [7:0] got;
    logic [7:0] want;
    int         tx_errors   = 0;
    int         ferr_errors = 0;
    int         ferr_count  = 0;

    assign errors    = tx_errors + ferr_errors;
    assign ferr_seen = ferr_count;

    task automatic expect_byte(input logic [7:0] b);
        exp_q.push_back(b);
    endtask

    function automatic int queued();
        return exp_q.size();
    endfunction

    // one 8N1 frame per pass, sampled on falling edges
    always begin
        @(negedge clk);
        if (!rst && !tx) begin
            repeat (BIT_CYCLES / 2) @(negedge clk);  // middle of the start bit
            if (tx) begin
                $display("checker: tx start bit went high early at %0t", $time);
                tx_errors++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    got = {tx, got[7:1]};  // lsb first
                end
                repeat (BIT_CYCLES) @(negedge clk);
                if (!tx) begin
                    $display("checker: tx stop bit was low at %0t", $time);
                    tx_errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("checker: tx sent byte %02h with nothing expected at %0t",
                             got, $time);
                    tx_errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (got != want) begin
                        $display("mismatch at %0t: tx byte %02h, expected %02h",
                                 $time, got, want);
                        tx_errors++;
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && frame_err) begin
            ferr_count++;
            if (!ferr_expected) begin
                $display("checker: frame error raised when none was expected at %0t", $time);
                ferr_errors++;
            end
        end
    end

endmodule

//--- test/tb_serial_mem_bridge.sv
// ********************
// rows go out bit-serially on rx, tx is decoded and compared by bridge_checker
// reads only touch addresses that an earlier row has written
// ********************
`timescale 1ns/1ps
`include "bridge_settings.svh"

module tb_serial_mem_bridge;

    localparam int BIT_CYCLES = `BRIDGE_BIT_CYCLES;
    localparam int ADDR_W     = `BRIDGE_ADDR_W;
    localparam int RAM_SIZE   = 1 << ADDR_W;
    localparam int ROWS       = 11;

    logic clk;
    logic rst;
    logic rx;
    logic tx;
    logic busy;
    logic frame_err;
    logic ferr_expected;
    int   errors;
    int   ferr_seen;
    int   pass_count;
    int   fail_count;

    logic [7:0]  row_op   [0:ROWS-1];
    logic [15:0] row_addr [0:ROWS-1];
    logic [7:0]  row_len  [0:ROWS-1];  // 0 stands for 256
    logic        row_ferr [0:ROWS-1];
    string       row_name [0:ROWS-1];
    logic [7:0]  shadow   [0:RAM_SIZE-1];

    serial_mem_bridge serial_mem_bridge_inst (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .tx        (tx),
        .busy      (busy),
        .frame_err (frame_err)
    );

    bridge_checker bridge_checker_inst (
        .clk           (clk),
        .rst           (rst),
        .tx            (tx),
        .frame_err     (frame_err),
        .ferr_expected (ferr_expected),
        .errors        (errors),
        .ferr_seen     (ferr_seen)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_row(input int i, input logic [7:0] op, input logic [15:0] addr,
                           input logic [7:0] len, input logic ferr, input string name);
        row_op[i]   = op;
        row_addr[i] = addr;
        row_len[i]  = len;
        row_ferr[i] = ferr;
        row_name[i] = name;
    endtask

    // starts and ends on a falling edge
    task automatic send_byte(input logic [7:0] b, input logic stop_bit);
        logic [7:0] sh;
        sh = b;
        rx = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = sh[0];
            sh = sh >> 1;
            repeat (BIT_CYCLES) @(negedge clk);
        end
        rx = stop_bit;
        repeat (BIT_CYCLES) @(negedge clk);
        rx = 1'b1;
    endtask

    task automatic send_header(input int r);
        send_byte(row_op[r], 1'b1);
        send_byte(row_addr[r][15:8], 1'b1);
        send_byte(row_addr[r][7:0], 1'b1);
        send_byte(row_len[r], 1'b1);
    endtask

    task automatic wait_busy_low(input int limit, output logic done);
        int cycles;
        cycles = 0;
        while (busy && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        done = !busy;
    endtask

    task automatic wait_tx_drained(input int limit, output logic done);
        int cycles;
        cycles = 0;
        while (bridge_checker_inst.queued() != 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        done = (bridge_checker_inst.queued() == 0);
    endtask

    task automatic report_row(input string name, input logic ok);
        if (ok) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        int                seed_ret;
        int                n;
        int                err_before;
        int                ferr_before;
        logic              ok;
        logic              done;
        logic [7:0]        b;
        logic [ADDR_W-1:0] idx;

        rst = 1'b1;
        rx = 1'b1;
        ferr_expected = 1'b0;
        pass_count = 0;
        fail_count = 0;
        seed_ret = $urandom(32'hac7f_7a95);
        add_row(0, `BRIDGE_OP_WRITE, 16'h0010, 8'd16, 1'b0, "write_16");
        add_row(1, `BRIDGE_OP_READ, 16'h0010, 8'd16, 1'b0, "read_16");
        add_row(2, `BRIDGE_OP_WRITE, 16'h03fc, 8'd8, 1'b0, "write_wrap");
        add_row(3, `BRIDGE_OP_READ, 16'h03fc, 8'd8, 1'b0, "read_wrap");
        add_row(4, `BRIDGE_OP_READ, 16'h1410, 8'd16, 1'b0, "read_alias");
        add_row(5, `BRIDGE_OP_WRITE, 16'h0100, 8'd0, 1'b0, "write_256");
        add_row(6, `BRIDGE_OP_READ, 16'h0100, 8'd0, 1'b0, "read_256");
        add_row(7, 8'h41, 16'h0000, 8'd1, 1'b0, "stray_opcode");
        add_row(8, `BRIDGE_OP_READ, 16'h0010, 8'd4, 1'b0, "read_after_stray");
        add_row(9, `BRIDGE_OP_READ, 16'h0000, 8'd1, 1'b1, "frame_error");
        add_row(10, `BRIDGE_OP_READ, 16'h03fc, 8'd8, 1'b0, "read_after_ferr");
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        ok = 1'b1;
        repeat (4 * BIT_CYCLES) begin  // line quiet until the first opcode
            @(negedge clk);
            if (!tx || busy) ok = 1'b0;
        end
        report_row("reset_idle", ok);

        for (int r = 0; r < ROWS; r++) begin
            err_before = errors;
            ferr_before = ferr_seen;
            ok = 1'b1;
            n = (row_len[r] == 8'd0) ? 256 : int'(row_len[r]);
            idx = ADDR_W'(row_addr[r]);  // upper address bits alias
            if (row_ferr[r]) begin
                ferr_expected = 1'b1;
                send_byte(row_op[r], 1'b0);
                repeat (BIT_CYCLES) @(negedge clk);
                ferr_expected = 1'b0;
                if (ferr_seen == ferr_before) begin
                    $display("frame error was not raised for a low stop bit");
                    ok = 1'b0;
                end
            end else if (row_op[r] == `BRIDGE_OP_WRITE) begin
                send_header(r);
                if (!busy) begin
                    $display("busy did not rise after a valid command header");
                    ok = 1'b0;
                end
                for (int k = 0; k < n; k++) begin
                    b = 8'($urandom);
                    shadow[idx] = b;
                    send_byte(b, 1'b1);
                    idx = idx + 1'b1;
                end
            end else if (row_op[r] == `BRIDGE_OP_READ) begin
                for (int k = 0; k < n; k++) begin
                    bridge_checker_inst.expect_byte(shadow[idx]);
                    idx = idx + 1'b1;
                end
                send_header(r);
                if (!busy) begin
                    $display("busy did not rise after a valid command header");
                    ok = 1'b0;
                end
            end else begin
                send_byte(row_op[r], 1'b1);  // unknown opcode, should be dropped
                repeat (BIT_CYCLES) @(negedge clk);
            end
            if ((row_ferr[r] || row_op[r] == 8'h41) && busy) begin
                $display("engine left idle after a byte it should have dropped");
                ok = 1'b0;
            end
            wait_busy_low((n + 4) * 12 * BIT_CYCLES, done);
            if (!done) begin
                $display("timed out waiting for busy to fall in row %s", row_name[r]);
                ok = 1'b0;
            end
            wait_tx_drained((n + 4) * 12 * BIT_CYCLES, done);
            if (!done) begin
                $display("timed out waiting for tx bytes in row %s", row_name[r]);
                ok = 1'b0;
            end
            if (errors != err_before) ok = 1'b0;
            report_row(row_name[r], ok);
        end

        $display("tests passed %0d, failed %0d, checker errors %0d",
                 pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
